/* include/mem_config.svh */
// Data memory configuration
// Word geometry for the byte-addressable RAM

`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// Word address width, 1024 words deep
`define MEM_ADDR_W 10

// Full word width in bits
`define MEM_DATA_W 32

// One byte lane
`define MEM_COL_W 8

`endif

/* logic/mem_types_pkg.sv */
// Storage side types
// Words, word indices and lane masks of the RAM

`include "mem_config.svh"

package mem_types_pkg;

   // Byte lanes in one word
   localparam int NUM_LANES = `MEM_DATA_W / `MEM_COL_W;

   // One stored word
   typedef logic [`MEM_DATA_W-1:0] word_t;

   // Index of a word inside the RAM
   typedef logic [`MEM_ADDR_W-1:0] word_addr_t;

   // One write enable per byte lane, lane 0 is the low byte
   typedef logic [NUM_LANES-1:0] lane_mask_t;

endpackage

/* logic/bus_types_pkg.sv */
// Port side types
// Byte addressing as seen by the processor

`include "mem_config.svh"

package bus_types_pkg;

   // Bits needed to pick a byte within a word
   localparam int OFFSET_W = $clog2(`MEM_DATA_W / `MEM_COL_W);

   // Byte offset inside a word
   typedef logic [OFFSET_W-1:0] byte_offset_t;

   // Full byte address, word index on top of the offset
   typedef logic [`MEM_ADDR_W+OFFSET_W-1:0] byte_addr_t;

endpackage

/* logic/ram_if.sv */
// RAM access bundle
// Word port between the port logic and the byte-enable RAM

interface ram_if;

   logic                     en;   // Access this cycle
   mem_types_pkg::lane_mask_t we;   // Per lane write enable
   mem_types_pkg::word_addr_t addr; // Word index
   mem_types_pkg::word_t      din;  // Write data, all lanes
   mem_types_pkg::word_t      dout; // Old word, one clock later

   // Port logic side
   modport ctrl (
      output en,
      output we,
      output addr,
      output din,
      input  dout
   );

   // RAM side
   modport mem (
      input  en,
      input  we,
      input  addr,
      input  din,
      output dout
   );

endinterface

/* logic/sp_ram.sv */
// Single port RAM column
// Read-first, one access per clock

module sp_ram #(
   parameter int ADDR_W = 10,
   parameter int DATA_W = 8
) (
   input  logic              clk,
   input  logic              en,
   input  logic              we,
   input  logic [ADDR_W-1:0] addr,
   input  logic [DATA_W-1:0] data_in,
   output logic [DATA_W-1:0] data_out
);

   localparam int DEPTH = 2 ** ADDR_W;

   // Storage array
   logic [DATA_W-1:0] mem [DEPTH];

   // Write and read share the clock edge. The nonblocking
   // update means data_out sees the contents before the write
   always_ff @(posedge clk) begin
      if (en) begin
         if (we) begin
            mem[addr] <= data_in;
         end
         data_out <= mem[addr]; // Read-first
      end
   end

endmodule

/* logic/sp_ram_be.sv */
// Byte write enable RAM
// One single port column per byte lane

`include "mem_config.svh"

module sp_ram_be #(
   parameter int ADDR_W = 10,
   parameter int DATA_W = 32
) (
   input logic clk,
   ram_if.mem  ram
);

   localparam int COL_W   = `MEM_COL_W;
   localparam int NUM_COL = DATA_W / COL_W;

   // Each lane sees the shared enable and address
   // and only its own slice of the data
   for (genvar i = 0; i < NUM_COL; i++) begin : g_col
      sp_ram #(
         .ADDR_W (ADDR_W),
         .DATA_W (COL_W)
      ) i_col (
         .clk      (clk),
         .en       (ram.en),
         .we       (ram.we[i]),
         .addr     (ram.addr),
         .data_in  (ram.din[i*COL_W +: COL_W]),
         .data_out (ram.dout[i*COL_W +: COL_W])
      );
   end

   // Lane enables from the port logic only ever come with an access
   a_we_needs_en : assert property (
      @(posedge clk) (|ram.we) |-> ram.en
   ) else $error("sp_ram_be: lane write enable without en");

endmodule

/* logic/mem_port_ctrl.sv */
// Native memory port logic
// Byte strobe check, word addressing and response pulses

module mem_port_ctrl (
   input  logic                      clk,
   input  logic                      arst_n,
   input  logic                      valid,
   input  bus_types_pkg::byte_addr_t addr,
   input  mem_types_pkg::word_t      wdata,
   input  mem_types_pkg::lane_mask_t wstrb,
   output logic                      ready,
   output logic                      err,
   ram_if.ctrl                       ram
);

   localparam int OFF_W = $bits(bus_types_pkg::byte_offset_t);
   localparam int WA_W  = $bits(mem_types_pkg::word_addr_t);

   mem_types_pkg::word_addr_t   word_addr;
   bus_types_pkg::byte_offset_t offset;
   logic                        is_write;
   logic                        strobe_ok;
   logic                        req_err;

   // Address split
   assign offset    = addr[OFF_W-1:0];
   assign word_addr = addr[OFF_W +: WA_W];

   assign is_write = |wstrb; // Zero strobe is a read

   // Strobe must be an aligned byte, halfword or word
   always_comb begin
      case (wstrb)
         4'b0001: strobe_ok = (offset == 2'd0);
         4'b0010: strobe_ok = (offset == 2'd1);
         4'b0100: strobe_ok = (offset == 2'd2);
         4'b1000: strobe_ok = (offset == 2'd3);
         4'b0011: strobe_ok = (offset == 2'd0); // Low halfword
         4'b1100: strobe_ok = (offset == 2'd2); // High halfword
         4'b1111: strobe_ok = (offset == 2'd0); // Full word
         default: strobe_ok = 1'b0;
      endcase
   end

   // Refused write, flagged on the response
   assign req_err = valid && is_write && !strobe_ok;

   // RAM request in the same cycle as the port request.
   // A refused write still reads so the response carries the stored word
   assign ram.en   = valid;
   assign ram.addr = word_addr;
   assign ram.din  = wdata;
   assign ram.we   = (valid && !req_err) ? wstrb : '0;

   // Response pulses, one cycle after the request
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ready <= 1'b0;
         err   <= 1'b0;
      end else begin
         ready <= valid;
         err   <= req_err;
      end
   end

   // No response without a request the cycle before
   a_ready_after_valid : assert property (
      @(posedge clk) disable iff (!arst_n) ready |-> $past(valid)
   ) else $error("mem_port_ctrl: ready without a prior request");

   // Error only comes with a response
   a_err_ready : assert property (
      @(posedge clk) disable iff (!arst_n) err |-> ready
   ) else $error("mem_port_ctrl: err outside a response");

endmodule

/* logic/data_mem.sv */
// Byte addressable data memory
// Native port logic in front of a byte-enable RAM

`include "mem_config.svh"

module data_mem (
   input  logic                      clk,
   input  logic                      arst_n,
   input  logic                      valid,
   input  bus_types_pkg::byte_addr_t addr,
   input  mem_types_pkg::word_t      wdata,
   input  mem_types_pkg::lane_mask_t wstrb,
   output mem_types_pkg::word_t      rdata,
   output logic                      ready,
   output logic                      err
);

   // Word access bus between port logic and RAM
   ram_if ram_bus ();

   mem_port_ctrl i_ctrl (
      .clk    (clk),
      .arst_n (arst_n),
      .valid  (valid),
      .addr   (addr),
      .wdata  (wdata),
      .wstrb  (wstrb),
      .ready  (ready),
      .err    (err),
      .ram    (ram_bus.ctrl)
   );

   sp_ram_be #(
      .ADDR_W (`MEM_ADDR_W),
      .DATA_W (`MEM_DATA_W)
   ) i_ram (
      .clk (clk),
      .ram (ram_bus.mem)
   );

   // Read data lines up with the ready pulse
   assign rdata = ram_bus.dout;

endmodule

/* tb/data_mem_tb.sv */
// Data memory testbench
// Random traffic checked against a shadow word model

`include "mem_config.svh"

module data_mem_tb;

   localparam int CLK_HALF = 4;
   localparam int WINDOW   = 16;  // Words the traffic is kept inside
   localparam int RAND_N   = 400; // Random requests after the preload
   localparam int DEPTH    = 2 ** `MEM_ADDR_W;
   localparam int COL_W    = `MEM_COL_W;
   localparam int LANES    = $bits(mem_types_pkg::lane_mask_t);

   // Reset, preload, random phase with gaps, readback, then margin
   localparam int TIMEOUT_CYCLES = 2 + 3 + WINDOW + 2 * RAND_N + WINDOW + 100;

   localparam mem_types_pkg::word_addr_t BASE = 10'h2a0;

   logic                      clk;
   logic                      arst_n;
   logic                      valid;
   bus_types_pkg::byte_addr_t addr;
   mem_types_pkg::word_t      wdata;
   mem_types_pkg::lane_mask_t wstrb;
   mem_types_pkg::word_t      rdata;
   logic                      ready;
   logic                      err;

   int seed = 32'h06baa4e9;
   int errors;
   int req_count;
   int resp_count;
   int refused_count;

   // Shadow of the RAM, with the lanes that hold a known value
   mem_types_pkg::word_t      shadow [DEPTH];
   mem_types_pkg::lane_mask_t known  [DEPTH];

   // Expected response for the request of the previous cycle
   logic                      exp_ready;
   logic                      exp_err;
   logic                      exp_write;
   mem_types_pkg::word_t      exp_rdata;
   mem_types_pkg::word_t      exp_bits; // Bits worth comparing

   mem_types_pkg::word_addr_t   req_word;
   bus_types_pkg::byte_offset_t req_off;
   logic                        req_legal;

   data_mem i_data_mem (
      .clk    (clk),
      .arst_n (arst_n),
      .valid  (valid),
      .addr   (addr),
      .wdata  (wdata),
      .wstrb  (wstrb),
      .rdata  (rdata),
      .ready  (ready),
      .err    (err)
   );

   initial begin
      clk = 1'b0;
      forever #CLK_HALF clk = ~clk;
   end

   // Aligned byte, halfword or word for the given offset
   function automatic logic strobe_is_legal(mem_types_pkg::lane_mask_t s,
                                            bus_types_pkg::byte_offset_t off);
      logic ok;
      ok = 1'b0;
      if (s == (mem_types_pkg::lane_mask_t'(1) << off)) begin
         ok = 1'b1; // Single byte in its own lane
      end else if (!off[0] && s == (mem_types_pkg::lane_mask_t'(3) << off)) begin
         ok = 1'b1;
      end else if (off == '0 && s == '1) begin
         ok = 1'b1;
      end
      return ok;
   endfunction

   // Spread a lane mask over the bits of a word
   function automatic mem_types_pkg::word_t lane_bits(mem_types_pkg::lane_mask_t m);
      mem_types_pkg::word_t bits;
      for (int i = 0; i < LANES; i++) begin
         bits[i*COL_W +: COL_W] = {COL_W{m[i]}};
      end
      return bits;
   endfunction

   // One clock of stimulus
   task automatic drive_cycle(input logic v, input bus_types_pkg::byte_addr_t a,
                              input mem_types_pkg::word_t d,
                              input mem_types_pkg::lane_mask_t s);
      @(posedge clk);
      valid <= v;
      addr  <= a;
      wdata <= d;
      wstrb <= s;
      if (v) begin
         req_count++;
      end
   endtask

   task automatic idle_cycle();
      drive_cycle(1'b0, '0, '0, '0);
   endtask

   // Read, legal write of some size, or a raw strobe that may be refused
   task automatic random_request();
      int                          r;
      mem_types_pkg::word_addr_t   w;
      bus_types_pkg::byte_offset_t off;
      mem_types_pkg::lane_mask_t   s;
      mem_types_pkg::word_t        d;
      r   = $random(seed);
      d   = $random(seed);
      w   = BASE + mem_types_pkg::word_addr_t'(r[7:4]);
      off = r[9:8];
      case (r[11:10])
         2'd0: s = '0;
         2'd1: s = mem_types_pkg::lane_mask_t'(1) << off;
         2'd2: begin
            if (r[12]) begin
               off = '0;
               s   = '1; // Full word
            end else begin
               off[0] = 1'b0;
               s      = mem_types_pkg::lane_mask_t'(3) << off;
            end
         end
         default: s = r[19:16];
      endcase
      if (r[22:21] == 2'b00) begin
         idle_cycle(); // Break up the back-to-back runs now and then
      end
      drive_cycle(1'b1, {w, off}, d, s);
   endtask

   // Shadow model, sampled on the same edge as the DUT
   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         exp_ready <= 1'b0;
         exp_err   <= 1'b0;
         exp_write <= 1'b0;
         exp_rdata <= '0;
         exp_bits  <= '0;
      end else begin
         exp_ready <= valid;
         exp_err   <= 1'b0;
         if (valid) begin
            req_word  = addr[$bits(addr)-1 -: `MEM_ADDR_W];
            req_off   = addr[$bits(req_off)-1:0];
            req_legal = strobe_is_legal(wstrb, req_off);
            exp_write <= |wstrb;
            exp_err   <= (|wstrb) && !req_legal;
            exp_rdata <= shadow[req_word]; // Old contents, read-first
            exp_bits  <= lane_bits(known[req_word]);
            if ((|wstrb) && req_legal) begin
               for (int i = 0; i < LANES; i++) begin
                  if (wstrb[i]) begin
                     shadow[req_word][i*COL_W +: COL_W] = wdata[i*COL_W +: COL_W];
                  end
               end
               known[req_word] = known[req_word] | wstrb;
            end else if (|wstrb) begin
               refused_count++;
            end
         end
         if (ready) begin
            resp_count++;
         end
      end
   end

   // Quiet outputs while reset is held
   a_reset_quiet : assert property (
      @(posedge clk) !arst_n |-> (!ready && !err)
   ) else begin
      errors++;
      $display("ERROR %0t: ready or err high during reset", $time);
   end

   a_ready_pulse : assert property (
      @(posedge clk) disable iff (!arst_n) ready == exp_ready
   ) else begin
      errors++;
      $display("ERROR %0t: ready is %b, expected %b", $time,
               $sampled(ready), $sampled(exp_ready));
   end

   // Only refused writes flag an error
   a_err_flag : assert property (
      @(posedge clk) disable iff (!arst_n) err == exp_err
   ) else begin
      errors++;
      $display("ERROR %0t: err is %b, expected %b", $time,
               $sampled(err), $sampled(exp_err));
   end

   a_read_data : assert property (
      @(posedge clk) disable iff (!arst_n)
         (ready && !exp_write) |-> ((rdata & exp_bits) == (exp_rdata & exp_bits))
   ) else begin
      errors++;
      $display("ERROR %0t: read returned %h, expected %h under mask %h", $time,
               $sampled(rdata), $sampled(exp_rdata), $sampled(exp_bits));
   end

   // Writes, refused ones too, return the word as it was
   a_write_old_data : assert property (
      @(posedge clk) disable iff (!arst_n)
         (ready && exp_write) |-> ((rdata & exp_bits) == (exp_rdata & exp_bits))
   ) else begin
      errors++;
      $display("ERROR %0t: write returned %h, expected old word %h under mask %h",
               $time, $sampled(rdata), $sampled(exp_rdata), $sampled(exp_bits));
   end

   initial begin
      #(TIMEOUT_CYCLES * 2 * CLK_HALF);
      $display("Run timed out with %0d of %0d requests answered", resp_count, req_count);
      $display("Verification failed");
      $finish;
   end

   initial begin
      mem_types_pkg::word_t d;
      int                   r;
      arst_n        = 1'b0;
      valid         = 1'b0;
      addr          = '0;
      wdata         = '0;
      wstrb         = '0;
      errors        = 0;
      req_count     = 0;
      resp_count    = 0;
      refused_count = 0;
      for (int i = 0; i < DEPTH; i++) begin
         known[i] = '0;
      end
      repeat (2) @(posedge clk);
      arst_n <= 1'b1;
      repeat (3) idle_cycle(); // No response before the first request

      // Fill the window with whole words
      for (int i = 0; i < WINDOW; i++) begin
         d = $random(seed);
         drive_cycle(1'b1, {BASE + mem_types_pkg::word_addr_t'(i), 2'b00}, d, '1);
      end

      for (int n = 0; n < RAND_N; n++) begin
         random_request();
      end

      // Read every word back, offset ignored
      for (int i = 0; i < WINDOW; i++) begin
         r = $random(seed);
         drive_cycle(1'b1, {BASE + mem_types_pkg::word_addr_t'(i), r[1:0]}, r, '0);
      end
      idle_cycle();

      while (resp_count != req_count) begin
         @(posedge clk);
      end
      repeat (4) @(posedge clk); // Trailing cycles, no stray ready

      $display("Requests %0d, responses %0d, refused writes %0d, errors %0d",
               req_count, resp_count, refused_count, errors);
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

/* sim.f */
+incdir+include
logic/mem_types_pkg.sv
logic/bus_types_pkg.sv
logic/ram_if.sv
logic/sp_ram.sv
logic/sp_ram_be.sv
logic/mem_port_ctrl.sv
logic/data_mem.sv
tb/data_mem_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the data memory simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --top-module data_mem_tb \
   -f sim.f

out=$(./obj_dir/Vdata_mem_tb)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Verification passed"; then
   exit 0
else
   exit 1
fi
